// ==== verilog/pcie_wr_pkg.sv ====
package pcie_wr_pkg;

  // Stream beat and staging word width
  localparam int data_w = 64;

  // Host side address and descriptor fields
  localparam int pcie_addr_w = 64;
  localparam int len_w       = 16;
  localparam int host_tag_w  = 8;

  // Card address bits below the core select field
  localparam int core_addr_w = 16;

  // Life cycle of one staging slot
  typedef enum logic [1:0] {
    slot_free,
    slot_filling,
    slot_full
  } slot_state_e;

endpackage

// ==== verilog/slot_if.sv ====
`timescale 1ns/100ps

interface slot_if import pcie_wr_pkg::*; #(
  parameter int core_count = 4,
  parameter int slot_words = 8
);
  localparam int core_w = $clog2(core_count);
  localparam int word_w = $clog2(slot_words);
  localparam int cnt_w  = $clog2(slot_words + 1);

  // Fill side, from the stream sink
  logic                   wr_en;
  logic [word_w-1:0]      wr_idx;
  logic [data_w-1:0]      wr_data;
  logic                   hdr_load;
  logic [pcie_addr_w-1:0] hdr_addr;
  logic [core_w-1:0]      hdr_core;
  logic                   wr_last;
  slot_state_e            state;

  // Drain side, towards the descriptor issuer
  logic [word_w-1:0]      rd_idx;
  logic                   rel;
  logic [cnt_w-1:0]       word_cnt;
  logic [pcie_addr_w-1:0] pcie_addr;
  logic [core_w-1:0]      core_id;
  logic [data_w-1:0]      rd_data;

  modport sink (
    output wr_en, wr_idx, wr_data, hdr_load, hdr_addr, hdr_core, wr_last,
    input  state
  );

  modport buffer (
    input  wr_en, wr_idx, wr_data, hdr_load, hdr_addr, hdr_core, wr_last,
    input  rd_idx, rel,
    output state, word_cnt, pcie_addr, core_id, rd_data
  );

  modport issuer (
    output rd_idx, rel,
    input  state, word_cnt, pcie_addr, core_id, rd_data
  );

endinterface

// ==== verilog/write_req_router.sv ====
`timescale 1ns/100ps

module write_req_router import pcie_wr_pkg::*; #(
  parameter int core_count = 4,
  localparam int core_w = $clog2(core_count)
) (
  input  logic                          pcie_clk,
  input  logic                          pcie_rst,
  input  logic [pcie_addr_w-1:0]        host_desc_addr,
  input  logic [core_addr_w+core_w-1:0] host_desc_ram_addr,
  input  logic [len_w-1:0]              host_desc_len,
  input  logic [host_tag_w-1:0]         host_desc_tag,
  input  logic                          host_desc_valid,
  output logic                          host_desc_ready,
  output logic [127:0]                  core_ctrl_data,
  output logic [core_w-1:0]             core_ctrl_dest,
  output logic                          core_ctrl_valid,
  input  logic                          core_ctrl_ready,
  input  logic [core_w-1:0]             done_core,
  input  logic                          done_valid,
  output logic [host_tag_w-1:0]         done_host_tag
);

  logic [core_w-1:0]     dest_core;
  logic [127:0]          ctrl_msg;
  logic                  desc_acc;
  logic [host_tag_w-1:0] pend_tag [core_count];
  logic [core_count-1:0] pend_v;

  assign dest_core = host_desc_ram_addr[core_addr_w +: core_w];

  // One outstanding write per core, and no new message while one waits
  assign host_desc_ready = !pend_v[dest_core] && !core_ctrl_valid;
  assign desc_acc        = host_desc_valid && host_desc_ready;

  always_comb begin
    ctrl_msg                    = '0;
    ctrl_msg[127:64]            = host_desc_addr;
    ctrl_msg[32 +: core_addr_w] = host_desc_ram_addr[core_addr_w-1:0];
    ctrl_msg[len_w-1:0]         = host_desc_len;
  end

  always_ff @(posedge pcie_clk) begin
    if (desc_acc) begin
      core_ctrl_data      <= ctrl_msg;
      core_ctrl_dest      <= dest_core;
      pend_tag[dest_core] <= host_desc_tag;
    end
  end

  always_ff @(posedge pcie_clk) begin
    if (pcie_rst) begin
      core_ctrl_valid <= 1'b0;
      pend_v          <= '0;
    end else begin
      if (desc_acc) begin
        core_ctrl_valid <= 1'b1;
      end else if (core_ctrl_ready) begin
        core_ctrl_valid <= 1'b0;
      end
      if (done_valid) begin
        pend_v[done_core] <= 1'b0;
      end
      if (desc_acc) begin
        pend_v[dest_core] <= 1'b1;
      end
    end
  end

  assign done_host_tag = pend_tag[done_core];

endmodule

// ==== verilog/core_data_sink.sv ====
`timescale 1ns/100ps

module core_data_sink import pcie_wr_pkg::*; #(
  parameter int core_count = 4,
  parameter int slot_count = 4,
  parameter int slot_words = 8,
  localparam int core_w = $clog2(core_count),
  localparam int slot_w = $clog2(slot_count),
  localparam int word_w = $clog2(slot_words),
  localparam int cnt_w  = $clog2(slot_words + 1)
) (
  input  logic              pcie_clk,
  input  logic              pcie_rst,
  input  logic [data_w-1:0] core_tx_data,
  input  logic [core_w-1:0] core_tx_user,
  input  logic              core_tx_last,
  input  logic              core_tx_valid,
  output logic              core_tx_ready,
  slot_if.sink              slots [slot_count]
);

  typedef enum logic {st_idle, st_payload} sink_state_e;

  sink_state_e           state;
  logic [slot_count-1:0] free;
  logic [slot_count-1:0] taken;
  logic [slot_w-1:0]     free_slot;
  logic [slot_w-1:0]     cur_slot;
  logic [slot_w-1:0]     tgt_slot;
  logic [cnt_w-1:0]      beat_cnt;
  logic                  beat_acc;
  logic                  hdr_beat;
  logic                  word_wr;
  logic                  busy_next;

  always_comb begin
    free_slot = '0;
    for (int i = slot_count - 1; i >= 0; i--) begin
      if (free[i]) begin
        free_slot = slot_w'(i);
      end
    end
  end

  assign beat_acc = core_tx_valid && core_tx_ready;
  assign hdr_beat = beat_acc && (state == st_idle);
  // Beats past the slot capacity are dropped
  assign word_wr  = beat_acc && (state == st_payload) && (beat_cnt < cnt_w'(slot_words));
  assign tgt_slot = (state == st_idle) ? free_slot : cur_slot;
  assign taken    = hdr_beat ? (slot_count'(1) << free_slot) : '0;

  assign busy_next = (state == st_payload) ? !(beat_acc && core_tx_last)
                                           : (hdr_beat && !core_tx_last);

  for (genvar i = 0; i < slot_count; i++) begin : g_slot
    assign free[i]           = (slots[i].state == slot_free);
    assign slots[i].hdr_load = hdr_beat && (free_slot == slot_w'(i));
    assign slots[i].hdr_addr = core_tx_data[pcie_addr_w-1:0];
    assign slots[i].hdr_core = core_tx_user;
    assign slots[i].wr_en    = word_wr && (cur_slot == slot_w'(i));
    assign slots[i].wr_idx   = beat_cnt[word_w-1:0];
    assign slots[i].wr_data  = core_tx_data;
    assign slots[i].wr_last  = beat_acc && core_tx_last && (tgt_slot == slot_w'(i));
  end

  always_ff @(posedge pcie_clk) begin
    if (hdr_beat) begin
      cur_slot <= free_slot;
    end
  end

  always_ff @(posedge pcie_clk) begin
    if (pcie_rst) begin
      state         <= st_idle;
      beat_cnt      <= '0;
      core_tx_ready <= 1'b0;
    end else begin
      state <= busy_next ? st_payload : st_idle;
      if (hdr_beat) begin
        beat_cnt <= '0;
      end else if (word_wr) begin
        beat_cnt <= beat_cnt + 1'b1;
      end
      // Freed slots show up one cycle late here, never too early
      core_tx_ready <= busy_next || |(free & ~taken);
    end
  end

endmodule

// ==== verilog/slot_buffer.sv ====
`timescale 1ns/100ps

module slot_buffer import pcie_wr_pkg::*; #(
  parameter int core_count = 4,
  parameter int slot_words = 8,
  localparam int core_w = $clog2(core_count),
  localparam int cnt_w  = $clog2(slot_words + 1)
) (
  input  logic   pcie_clk,
  input  logic   pcie_rst,
  slot_if.buffer port
);

  logic [data_w-1:0]      mem [slot_words];
  logic [data_w-1:0]      rd_data_r;
  logic [pcie_addr_w-1:0] addr_r;
  logic [core_w-1:0]      core_r;
  logic [cnt_w-1:0]       cnt_r;
  slot_state_e            state_r;

  always_ff @(posedge pcie_clk) begin
    if (port.wr_en) begin
      mem[port.wr_idx] <= port.wr_data;
    end
    if (port.hdr_load) begin
      addr_r <= port.hdr_addr;
      core_r <= port.hdr_core;
    end
    rd_data_r <= mem[port.rd_idx];
  end

  always_ff @(posedge pcie_clk) begin
    if (pcie_rst) begin
      state_r <= slot_free;
      cnt_r   <= '0;
    end else begin
      // Last flag wins, so a header-only packet goes straight to full
      if (port.rel) begin
        state_r <= slot_free;
      end else if (port.wr_last) begin
        state_r <= slot_full;
      end else if (port.hdr_load) begin
        state_r <= slot_filling;
      end
      if (port.hdr_load) begin
        cnt_r <= '0;
      end else if (port.wr_en) begin
        cnt_r <= cnt_r + 1'b1;
      end
    end
  end

  assign port.state     = state_r;
  assign port.word_cnt  = cnt_r;
  assign port.pcie_addr = addr_r;
  assign port.core_id   = core_r;
  assign port.rd_data   = rd_data_r;

endmodule

// ==== verilog/pcie_desc_issuer.sv ====
`timescale 1ns/100ps

module pcie_desc_issuer import pcie_wr_pkg::*; #(
  parameter int core_count = 4,
  parameter int slot_count = 4,
  parameter int slot_words = 8,
  localparam int core_w = $clog2(core_count),
  localparam int slot_w = $clog2(slot_count),
  localparam int word_w = $clog2(slot_words),
  localparam int cnt_w  = $clog2(slot_words + 1),
  localparam int ram_w  = $clog2(slot_count * slot_words * 8)
) (
  input  logic                      pcie_clk,
  input  logic                      pcie_rst,
  slot_if.issuer                    slots [slot_count],
  output logic [pcie_addr_w-1:0]    pcie_desc_pcie_addr,
  output logic [ram_w-1:0]          pcie_desc_ram_addr,
  output logic [len_w-1:0]          pcie_desc_len,
  output logic [slot_w-1:0]         pcie_desc_tag,
  output logic                      pcie_desc_valid,
  input  logic                      pcie_desc_ready,
  input  logic [slot_w-1:0]         pcie_status_tag,
  input  logic                      pcie_status_valid,
  input  logic [slot_w+word_w-1:0]  dma_rd_addr,
  input  logic                      dma_rd_valid,
  output logic [data_w-1:0]         dma_rd_data,
  output logic                      dma_rd_data_valid,
  output logic [core_w-1:0]         done_core,
  output logic                      done_valid,
  input  logic [host_tag_w-1:0]     done_host_tag,
  output logic [host_tag_w-1:0]     host_status_tag,
  output logic                      host_status_valid
);

  logic [slot_count-1:0]  full;
  logic [slot_count-1:0]  issued;
  logic [slot_count-1:0]  cand;
  logic [cnt_w-1:0]       slot_cnt  [slot_count];
  logic [pcie_addr_w-1:0] slot_addr [slot_count];
  logic [core_w-1:0]      slot_core [slot_count];
  logic [data_w-1:0]      slot_rd   [slot_count];
  logic [slot_w-1:0]      pick;
  logic [slot_w-1:0]      rd_slot;
  logic [slot_w-1:0]      rd_slot_q;
  logic [word_w-1:0]      rd_word;
  logic                   issue;

  assign rd_slot = dma_rd_addr[word_w +: slot_w];
  assign rd_word = dma_rd_addr[word_w-1:0];

  for (genvar i = 0; i < slot_count; i++) begin : g_slot
    assign full[i]         = (slots[i].state == slot_full);
    assign slot_cnt[i]     = slots[i].word_cnt;
    assign slot_addr[i]    = slots[i].pcie_addr;
    assign slot_core[i]    = slots[i].core_id;
    assign slot_rd[i]      = slots[i].rd_data;
    assign slots[i].rd_idx = (dma_rd_valid && (rd_slot == slot_w'(i))) ? rd_word : '0;
    assign slots[i].rel    = pcie_status_valid && (pcie_status_tag == slot_w'(i));
  end

  // Lowest full slot that has no descriptor yet
  assign cand = full & ~issued;

  always_comb begin
    pick = '0;
    for (int i = slot_count - 1; i >= 0; i--) begin
      if (cand[i]) begin
        pick = slot_w'(i);
      end
    end
  end

  assign issue = !pcie_desc_valid && |cand;

  always_ff @(posedge pcie_clk) begin
    if (issue) begin
      pcie_desc_pcie_addr <= slot_addr[pick];
      pcie_desc_ram_addr  <= ram_w'(pick) * ram_w'(slot_words * 8);
      pcie_desc_len       <= len_w'(slot_cnt[pick]) << 3;
      pcie_desc_tag       <= pick;
    end
    rd_slot_q       <= rd_slot;
    host_status_tag <= done_host_tag;
  end

  always_ff @(posedge pcie_clk) begin
    if (pcie_rst) begin
      pcie_desc_valid   <= 1'b0;
      issued            <= '0;
      dma_rd_data_valid <= 1'b0;
      host_status_valid <= 1'b0;
    end else begin
      if (issue) begin
        pcie_desc_valid <= 1'b1;
      end else if (pcie_desc_ready) begin
        pcie_desc_valid <= 1'b0;
      end
      if (pcie_status_valid) begin
        issued[pcie_status_tag] <= 1'b0;
      end
      if (issue) begin
        issued[pick] <= 1'b1;
      end
      dma_rd_data_valid <= dma_rd_valid;
      host_status_valid <= pcie_status_valid;
    end
  end

  // Completion goes back to the router by the core that filled the slot
  assign done_core  = slot_core[pcie_status_tag];
  assign done_valid = pcie_status_valid;

  assign dma_rd_data = slot_rd[rd_slot_q];

endmodule

// ==== verilog/pcie_cont_write.sv ====
`timescale 1ns/100ps

module pcie_cont_write import pcie_wr_pkg::*; #(
  parameter int core_count = 4,
  parameter int slot_count = 4,
  parameter int slot_words = 8,
  localparam int core_w = $clog2(core_count),
  localparam int slot_w = $clog2(slot_count),
  localparam int word_w = $clog2(slot_words),
  localparam int ram_w  = $clog2(slot_count * slot_words * 8)
) (
  input  logic                          pcie_clk,
  input  logic                          pcie_rst,
  input  logic [pcie_addr_w-1:0]        host_desc_addr,
  input  logic [core_addr_w+core_w-1:0] host_desc_ram_addr,
  input  logic [len_w-1:0]              host_desc_len,
  input  logic [host_tag_w-1:0]         host_desc_tag,
  input  logic                          host_desc_valid,
  output logic                          host_desc_ready,
  output logic [host_tag_w-1:0]         host_status_tag,
  output logic                          host_status_valid,
  output logic [127:0]                  core_ctrl_data,
  output logic [core_w-1:0]             core_ctrl_dest,
  output logic                          core_ctrl_valid,
  input  logic                          core_ctrl_ready,
  input  logic [data_w-1:0]             core_tx_data,
  input  logic [core_w-1:0]             core_tx_user,
  input  logic                          core_tx_last,
  input  logic                          core_tx_valid,
  output logic                          core_tx_ready,
  output logic [pcie_addr_w-1:0]        pcie_desc_pcie_addr,
  output logic [ram_w-1:0]              pcie_desc_ram_addr,
  output logic [len_w-1:0]              pcie_desc_len,
  output logic [slot_w-1:0]             pcie_desc_tag,
  output logic                          pcie_desc_valid,
  input  logic                          pcie_desc_ready,
  input  logic [slot_w-1:0]             pcie_status_tag,
  input  logic                          pcie_status_valid,
  input  logic [slot_w+word_w-1:0]      dma_rd_addr,
  input  logic                          dma_rd_valid,
  output logic [data_w-1:0]             dma_rd_data,
  output logic                          dma_rd_data_valid
);

  logic [core_w-1:0]     done_core;
  logic                  done_valid;
  logic [host_tag_w-1:0] done_host_tag;

  slot_if #(.core_count(core_count), .slot_words(slot_words)) slot_bus [slot_count] ();

  write_req_router #(.core_count(core_count)) u_router (
    .pcie_clk           (pcie_clk),
    .pcie_rst           (pcie_rst),
    .host_desc_addr     (host_desc_addr),
    .host_desc_ram_addr (host_desc_ram_addr),
    .host_desc_len      (host_desc_len),
    .host_desc_tag      (host_desc_tag),
    .host_desc_valid    (host_desc_valid),
    .host_desc_ready    (host_desc_ready),
    .core_ctrl_data     (core_ctrl_data),
    .core_ctrl_dest     (core_ctrl_dest),
    .core_ctrl_valid    (core_ctrl_valid),
    .core_ctrl_ready    (core_ctrl_ready),
    .done_core          (done_core),
    .done_valid         (done_valid),
    .done_host_tag      (done_host_tag)
  );

  core_data_sink #(
    .core_count (core_count),
    .slot_count (slot_count),
    .slot_words (slot_words)
  ) u_sink (
    .pcie_clk      (pcie_clk),
    .pcie_rst      (pcie_rst),
    .core_tx_data  (core_tx_data),
    .core_tx_user  (core_tx_user),
    .core_tx_last  (core_tx_last),
    .core_tx_valid (core_tx_valid),
    .core_tx_ready (core_tx_ready),
    .slots         (slot_bus)
  );

  for (genvar i = 0; i < slot_count; i++) begin : g_slot
    slot_buffer #(
      .core_count (core_count),
      .slot_words (slot_words)
    ) u_slot (
      .pcie_clk (pcie_clk),
      .pcie_rst (pcie_rst),
      .port     (slot_bus[i])
    );
  end

  pcie_desc_issuer #(
    .core_count (core_count),
    .slot_count (slot_count),
    .slot_words (slot_words)
  ) u_issuer (
    .pcie_clk            (pcie_clk),
    .pcie_rst            (pcie_rst),
    .slots               (slot_bus),
    .pcie_desc_pcie_addr (pcie_desc_pcie_addr),
    .pcie_desc_ram_addr  (pcie_desc_ram_addr),
    .pcie_desc_len       (pcie_desc_len),
    .pcie_desc_tag       (pcie_desc_tag),
    .pcie_desc_valid     (pcie_desc_valid),
    .pcie_desc_ready     (pcie_desc_ready),
    .pcie_status_tag     (pcie_status_tag),
    .pcie_status_valid   (pcie_status_valid),
    .dma_rd_addr         (dma_rd_addr),
    .dma_rd_valid        (dma_rd_valid),
    .dma_rd_data         (dma_rd_data),
    .dma_rd_data_valid   (dma_rd_data_valid),
    .done_core           (done_core),
    .done_valid          (done_valid),
    .done_host_tag       (done_host_tag),
    .host_status_tag     (host_status_tag),
    .host_status_valid   (host_status_valid)
  );

endmodule

// ==== verification/pcie_cont_write_properties.sv ====
`timescale 1ns/100ps

module pcie_cont_write_properties import pcie_wr_pkg::*; (
  input logic                   pcie_clk,
  input logic                   pcie_rst,
  input logic [127:0]           core_ctrl_data,
  input logic                   core_ctrl_valid,
  input logic                   core_ctrl_ready,
  input logic [pcie_addr_w-1:0] pcie_desc_pcie_addr,
  input logic [len_w-1:0]       pcie_desc_len,
  input logic                   pcie_desc_valid,
  input logic                   pcie_desc_ready,
  input logic                   host_status_valid,
  input logic                   dma_rd_valid,
  input logic                   dma_rd_data_valid
);

  // Control message held while the core stalls
  assert property (@(posedge pcie_clk) disable iff (pcie_rst)
    core_ctrl_valid && !core_ctrl_ready |=> core_ctrl_valid && $stable(core_ctrl_data))
    else $error("core_ctrl dropped or changed before ready");

  assert property (@(posedge pcie_clk) disable iff (pcie_rst)
    pcie_desc_valid && !pcie_desc_ready |=>
      pcie_desc_valid && $stable(pcie_desc_pcie_addr) && $stable(pcie_desc_len))
    else $error("pcie_desc dropped or changed before ready");

  assert property (@(posedge pcie_clk) disable iff (pcie_rst)
    host_status_valid |=> !host_status_valid)
    else $error("host_status_valid longer than one cycle");

  // Read port answers exactly one cycle after each request
  assert property (@(posedge pcie_clk) disable iff (pcie_rst)
    dma_rd_valid |=> dma_rd_data_valid)
    else $error("dma_rd_data_valid missing after a read request");

  assert property (@(posedge pcie_clk) disable iff (pcie_rst)
    !dma_rd_valid |=> !dma_rd_data_valid)
    else $error("dma_rd_data_valid without a read request");

endmodule

// ==== verification/pcie_cont_write_tb.sv ====
`timescale 1ns/100ps

module pcie_cont_write_tb import pcie_wr_pkg::*; ();

  localparam int core_count     = 4;
  localparam int slot_count     = 4;
  localparam int slot_words     = 8;
  localparam int core_w         = $clog2(core_count);
  localparam int slot_w         = $clog2(slot_count);
  localparam int word_w         = $clog2(slot_words);
  localparam int ram_w          = $clog2(slot_count * slot_words * 8);
  localparam int rows           = 4;
  localparam int max_beats      = 12;
  localparam int timeout_cycles = 200;

  typedef struct {
    int                     core;
    logic [host_tag_w-1:0]  tag;
    logic [pcie_addr_w-1:0] addr;
    int                     beats;
    int                     hold;
  } xfer_t;

  logic                          pcie_clk = 1'b0;
  logic                          pcie_rst;
  logic [pcie_addr_w-1:0]        host_desc_addr;
  logic [core_addr_w+core_w-1:0] host_desc_ram_addr;
  logic [len_w-1:0]              host_desc_len;
  logic [host_tag_w-1:0]         host_desc_tag;
  logic                          host_desc_valid;
  logic                          host_desc_ready;
  logic [host_tag_w-1:0]         host_status_tag;
  logic                          host_status_valid;
  logic [127:0]                  core_ctrl_data;
  logic [core_w-1:0]             core_ctrl_dest;
  logic                          core_ctrl_valid;
  logic                          core_ctrl_ready;
  logic [data_w-1:0]             core_tx_data;
  logic [core_w-1:0]             core_tx_user;
  logic                          core_tx_last;
  logic                          core_tx_valid;
  logic                          core_tx_ready;
  logic [pcie_addr_w-1:0]        pcie_desc_pcie_addr;
  logic [ram_w-1:0]              pcie_desc_ram_addr;
  logic [len_w-1:0]              pcie_desc_len;
  logic [slot_w-1:0]             pcie_desc_tag;
  logic                          pcie_desc_valid;
  logic                          pcie_desc_ready;
  logic [slot_w-1:0]             pcie_status_tag;
  logic                          pcie_status_valid;
  logic [slot_w+word_w-1:0]      dma_rd_addr;
  logic                          dma_rd_valid;
  logic [data_w-1:0]             dma_rd_data;
  logic                          dma_rd_data_valid;

  xfer_t             table_rows [rows];
  logic [data_w-1:0] payload [rows][max_beats];
  integer            seed;

  pcie_cont_write #(
    .core_count (core_count),
    .slot_count (slot_count),
    .slot_words (slot_words)
  ) UUT (.*);

  bind pcie_cont_write pcie_cont_write_properties u_props (
    .pcie_clk            (pcie_clk),
    .pcie_rst            (pcie_rst),
    .core_ctrl_data      (core_ctrl_data),
    .core_ctrl_valid     (core_ctrl_valid),
    .core_ctrl_ready     (core_ctrl_ready),
    .pcie_desc_pcie_addr (pcie_desc_pcie_addr),
    .pcie_desc_len       (pcie_desc_len),
    .pcie_desc_valid     (pcie_desc_valid),
    .pcie_desc_ready     (pcie_desc_ready),
    .host_status_valid   (host_status_valid),
    .dma_rd_valid        (dma_rd_valid),
    .dma_rd_data_valid   (dma_rd_data_valid)
  );

  always #4 pcie_clk = ~pcie_clk;

  function automatic logic [core_addr_w-1:0] card_offset(input int r);
    return core_addr_w'(16'h0100 * r + 16'h0040);
  endfunction

  // Control message with the host address on top, the card offset at 47:32 and the length low
  function automatic logic [127:0] ctrl_word(input logic [pcie_addr_w-1:0] addr,
                                             input logic [core_addr_w-1:0] ofs,
                                             input logic [len_w-1:0] len);
    return {addr, 16'h0000, ofs, 16'h0000, len};
  endfunction

  function automatic int stored_words(input int beats);
    return (beats > slot_words) ? slot_words : beats;
  endfunction

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("Some tests failed");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic check(input string name, input logic [127:0] got, input logic [127:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp));
    end
  endtask

  task automatic offer_host_desc(input int core, input logic [host_tag_w-1:0] tag,
                                 input logic [pcie_addr_w-1:0] addr,
                                 input logic [core_addr_w-1:0] ofs,
                                 input logic [len_w-1:0] len);
    host_desc_addr     <= addr;
    host_desc_ram_addr <= {core_w'(core), ofs};
    host_desc_len      <= len;
    host_desc_tag      <= tag;
    host_desc_valid    <= 1'b1;
  endtask

  task automatic wait_host_accept();
    int n;
    n = 0;
    do begin
      @(posedge pcie_clk);
      n++;
      if (n > timeout_cycles) abort_run("Timeout: host descriptor was never accepted");
    end while (!host_desc_ready);
    host_desc_valid <= 1'b0;
  endtask

  task automatic take_ctrl_msg(input int core, input logic [127:0] exp);
    int n;
    n = 0;
    do begin
      @(posedge pcie_clk);
      n++;
      if (n > timeout_cycles) abort_run("Timeout: no control message reached the core");
    end while (!core_ctrl_valid);
    check("core_ctrl_dest", core_ctrl_dest, core);
    check("core_ctrl_data", core_ctrl_data, exp);
    core_ctrl_ready <= 1'b1;
    @(posedge pcie_clk);
    core_ctrl_ready <= 1'b0;
  endtask

  // Core model sends a header beat with the host address and then the payload
  task automatic send_stream(input int r);
    int n;
    for (int b = 0; b <= table_rows[r].beats; b++) begin
      if (b == 0) begin
        core_tx_data <= table_rows[r].addr;
      end else begin
        core_tx_data <= payload[r][b-1];
      end
      core_tx_user  <= core_w'(table_rows[r].core);
      core_tx_last  <= (b == table_rows[r].beats);
      core_tx_valid <= 1'b1;
      n = 0;
      do begin
        @(posedge pcie_clk);
        n++;
        if (n > timeout_cycles) abort_run("Timeout: core stream beat was never accepted");
      end while (!core_tx_ready);
    end
    core_tx_valid <= 1'b0;
    core_tx_last  <= 1'b0;
  endtask

  // DMA model takes the descriptor of slot r and reads back every word
  task automatic run_dma(input int r);
    int n;
    int nw;
    nw = stored_words(table_rows[r].beats);
    n = 0;
    do begin
      @(posedge pcie_clk);
      n++;
      if (n > timeout_cycles) abort_run("Timeout: no DMA descriptor was issued");
    end while (!pcie_desc_valid);
    // Slots were all free before the streams, so row r landed in slot r
    check("pcie_desc_tag", pcie_desc_tag, r);
    check("pcie_desc_pcie_addr", pcie_desc_pcie_addr, table_rows[r].addr);
    check("pcie_desc_len", pcie_desc_len, nw * 8);
    check("pcie_desc_ram_addr", pcie_desc_ram_addr, r * slot_words * 8);
    repeat (table_rows[r].hold) @(posedge pcie_clk);
    check("pcie_desc_valid", pcie_desc_valid, 1);
    pcie_desc_ready <= 1'b1;
    @(posedge pcie_clk);
    pcie_desc_ready <= 1'b0;
    for (int w = 0; w <= nw; w++) begin
      if (w < nw) begin
        dma_rd_addr  <= (slot_w + word_w)'(r * slot_words + w);
        dma_rd_valid <= 1'b1;
      end else begin
        dma_rd_valid <= 1'b0;
      end
      @(posedge pcie_clk);
      if (w > 0) begin
        check("dma_rd_data_valid", dma_rd_data_valid, 1);
        check("dma_rd_data", dma_rd_data, payload[r][w-1]);
      end
    end
  endtask

  // A second request for the same core waits for the completion of slot r
  task automatic complete_with_retry(input int r);
    int n;
    logic [pcie_addr_w-1:0] addr2;
    addr2 = table_rows[r].addr + 64'h1000;
    offer_host_desc(table_rows[r].core, table_rows[r].tag ^ 8'h80, addr2, card_offset(r),
                    len_w'(table_rows[r].beats * 8));
    repeat (4) begin
      @(posedge pcie_clk);
      check("host_desc_ready", host_desc_ready, 0);
    end
    pcie_status_tag   <= slot_w'(r);
    pcie_status_valid <= 1'b1;
    @(posedge pcie_clk);
    check("host_desc_ready", host_desc_ready, 0);
    pcie_status_valid <= 1'b0;
    n = 0;
    do begin
      @(posedge pcie_clk);
      n++;
      if (n > timeout_cycles) abort_run("Timeout: host status never arrived");
    end while (!host_status_valid);
    check("host_status_tag", host_status_tag, table_rows[r].tag);
    check("host_desc_ready", host_desc_ready, 1);
    host_desc_valid <= 1'b0;
    take_ctrl_msg(table_rows[r].core,
                  ctrl_word(addr2, card_offset(r), len_w'(table_rows[r].beats * 8)));
  endtask

  initial begin
    seed = 32'h7c04_c1ec;
    pcie_rst           <= 1'b1;
    host_desc_addr     <= '0;
    host_desc_ram_addr <= '0;
    host_desc_len      <= '0;
    host_desc_tag      <= '0;
    host_desc_valid    <= 1'b0;
    core_ctrl_ready    <= 1'b0;
    core_tx_data       <= '0;
    core_tx_user       <= '0;
    core_tx_last       <= 1'b0;
    core_tx_valid      <= 1'b0;
    pcie_desc_ready    <= 1'b0;
    pcie_status_tag    <= '0;
    pcie_status_valid  <= 1'b0;
    dma_rd_addr        <= '0;
    dma_rd_valid       <= 1'b0;

    // Core, host tag, host address, data beats, DMA ready hold-off cycles
    table_rows[0] = '{2, 8'h11, 64'h0000_0001_2345_6000, 8, 3};
    table_rows[1] = '{0, 8'h22, 64'h0000_0002_0000_1100, 3, 0};
    table_rows[2] = '{3, 8'h33, 64'h0000_00ab_cdef_0040, 5, 2};
    table_rows[3] = '{1, 8'h44, 64'h0000_0003_8000_0000, 10, 1};
    for (int r = 0; r < rows; r++) begin
      for (int w = 0; w < max_beats; w++) begin
        payload[r][w] = {$random(seed), $random(seed)};
      end
    end

    repeat (2) @(posedge pcie_clk);
    pcie_rst <= 1'b0;
    check("core_ctrl_valid", core_ctrl_valid, 0);
    check("core_tx_ready", core_tx_ready, 0);
    check("pcie_desc_valid", pcie_desc_valid, 0);
    check("host_status_valid", host_status_valid, 0);
    check("dma_rd_data_valid", dma_rd_data_valid, 0);
    check("host_desc_ready", host_desc_ready, 1);

    for (int r = 0; r < rows; r++) begin
      offer_host_desc(table_rows[r].core, table_rows[r].tag, table_rows[r].addr,
                      card_offset(r), len_w'(table_rows[r].beats * 8));
      wait_host_accept();
      take_ctrl_msg(table_rows[r].core, ctrl_word(table_rows[r].addr, card_offset(r),
                                                  len_w'(table_rows[r].beats * 8)));
      send_stream(r);
    end

    for (int r = 0; r < rows; r++) begin
      run_dma(r);
      complete_with_retry(r);
    end

    // Every slot is free again and nothing is left to describe
    check("core_tx_ready", core_tx_ready, 1);
    check("pcie_desc_valid", pcie_desc_valid, 0);
    $display("All tests passed");
    $finish;
  end

endmodule

// ==== vlog.f ====
verilog/pcie_wr_pkg.sv
verilog/slot_if.sv
verilog/write_req_router.sv
verilog/core_data_sink.sv
verilog/slot_buffer.sv
verilog/pcie_desc_issuer.sv
verilog/pcie_cont_write.sv
verification/pcie_cont_write_properties.sv
verification/pcie_cont_write_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f vlog.f \
  --top-module pcie_cont_write_tb -o pcie_cont_write_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/pcie_cont_write_sim 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -q "All tests passed"; then
  exit 0
fi
exit 1
